// File: design/mc_cfg_pkg.sv
// Machine sizes and timing constants of the memory-side harness.
// Imported by every RTL module and by the testbench for sizes and latencies.
`default_nettype none

package mc_cfg_pkg;

  // vcache DMA ports and their split over the test DRAM channels
  localparam int NUM_VCACHES         = 4;
  localparam int VCACHES_PER_CHANNEL = 2;
  localparam int NUM_CHANNELS        = 2;

  // index of a vcache inside its channel, doubles as the bank bit
  localparam int SRC_WIDTH = 1;

  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;

  // modelled tag programming and the memory reset release after it
  localparam int TAG_PROGRAM_CYCLES = 16;
  localparam int TAG_CNT_WIDTH      = $clog2(TAG_PROGRAM_CYCLES);
  localparam int RESET_DEPTH        = 3;

  // accept cycle to response pulse
  localparam int MEM_READ_LATENCY = 4;

  typedef logic [ADDR_WIDTH-1:0] cache_addr_t;
  typedef logic [DATA_WIDTH-1:0] dma_data_t;

endpackage

`default_nettype wire

// File: design/mc_dram_pkg.sv
// Test DRAM address layout, operation codes and the tag sequencer states.
// A cache byte address is {bank, row, column, byte offset}; the channel
// word address puts the row first, then the bank bit, bank and column.
`default_nettype none

package mc_dram_pkg;

  localparam int RO_WIDTH          = 4;
  localparam int BA_WIDTH          = 2;
  localparam int CO_WIDTH          = 4;
  localparam int BYTE_OFFSET_WIDTH = 2;

  // field positions inside the cache byte address
  localparam int CO_LSB = BYTE_OFFSET_WIDTH;
  localparam int RO_LSB = CO_LSB + CO_WIDTH;
  localparam int BA_LSB = RO_LSB + RO_WIDTH;

  // row, bank bit, bank, column
  localparam int CH_ADDR_WIDTH = RO_WIDTH + 1 + BA_WIDTH + CO_WIDTH;
  localparam int DRAM_WORDS    = 2 ** CH_ADDR_WIDTH;

  typedef logic [CH_ADDR_WIDTH-1:0] dram_ch_addr_t;

  typedef enum logic {
    DRAM_READ  = 1'b0,
    DRAM_WRITE = 1'b1
  } dram_op_e;

  typedef enum logic [1:0] {
    TAG_IDLE    = 2'd0,
    TAG_PROGRAM = 2'd1,
    TAG_DONE    = 2'd2
  } tag_state_e;

endpackage

`default_nettype wire

// File: design/mc_reset_sequencer.sv
// Models the tag programming phase after reset. tag_done_o rises a fixed
// number of cycles after reset release and stays high; the memory reset
// follows it through a short register chain.
`timescale 1ns/1ns
`default_nettype none

module mc_reset_sequencer
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
(
  input  wire  clk_i,
  input  wire  rst_n_i,
  output logic tag_done_o,
  output logic mem_reset_o
);

  tag_state_e               state_q;
  tag_state_e               state_d;
  logic [TAG_CNT_WIDTH-1:0] cnt_q;
  logic [RESET_DEPTH-1:0]   rst_chain_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      TAG_IDLE: state_d = TAG_PROGRAM;
      TAG_PROGRAM: begin
        if (cnt_q == TAG_CNT_WIDTH'(TAG_PROGRAM_CYCLES - 1)) begin
          state_d = TAG_DONE;
        end
      end
      default: state_d = TAG_DONE;
    endcase
  end

  // counter runs from the first edge after reset, idle included
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TAG_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q != TAG_DONE) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign tag_done_o = (state_q == TAG_DONE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_chain_q <= '1;
    end else begin
      rst_chain_q <= {rst_chain_q[RESET_DEPTH-2:0], ~tag_done_o};
    end
  end

  assign mem_reset_o = rst_chain_q[RESET_DEPTH-1];

endmodule

`default_nettype wire

// File: design/mc_dma_channel_map.sv
// Maps the vcache DMA ports onto the test DRAM channels. Each channel
// grants one of its vcaches per cycle by round robin; yumi is combinational
// from the grant. Read returns are steered back by source index.
`timescale 1ns/1ns
`default_nettype none

module mc_dma_channel_map
  import mc_cfg_pkg::*;
(
  input  wire                                       clk_i,
  input  wire                                       rst_n_i,
  input  wire                                       mem_reset_i,

  input  wire  [NUM_VCACHES-1:0]                    req_v_i,
  input  wire  [NUM_VCACHES-1:0]                    req_op_i,
  input  cache_addr_t [NUM_VCACHES-1:0]             req_addr_i,
  input  dma_data_t   [NUM_VCACHES-1:0]             req_data_i,
  output logic [NUM_VCACHES-1:0]                    req_yumi_o,
  output logic [NUM_VCACHES-1:0]                    resp_v_o,
  output dma_data_t   [NUM_VCACHES-1:0]             resp_data_o,

  output logic [NUM_CHANNELS-1:0]                   ch_v_o,
  output logic [NUM_CHANNELS-1:0]                   ch_op_o,
  output cache_addr_t [NUM_CHANNELS-1:0]            ch_addr_o,
  output dma_data_t   [NUM_CHANNELS-1:0]            ch_data_o,
  output logic [NUM_CHANNELS-1:0][SRC_WIDTH-1:0]    ch_src_o,

  input  wire  [NUM_CHANNELS-1:0]                   ret_v_i,
  input  wire  [NUM_CHANNELS-1:0][SRC_WIDTH-1:0]    ret_src_i,
  input  dma_data_t   [NUM_CHANNELS-1:0]            ret_data_i
);

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_ch
    logic [SRC_WIDTH-1:0] rr_q;
    logic [SRC_WIDTH-1:0] pick;
    logic                 found;
    logic                 accept;

    // first requester at or after the pointer
    always_comb begin : arb
      logic [SRC_WIDTH-1:0] idx;
      found = 1'b0;
      pick  = rr_q;
      for (int i = 0; i < VCACHES_PER_CHANNEL; i++) begin
        idx = rr_q + SRC_WIDTH'(i);
        if (!found && req_v_i[c*VCACHES_PER_CHANNEL + int'(idx)]) begin
          found = 1'b1;
          pick  = idx;
        end
      end
    end

    // nothing is taken while the memory side is held in reset
    assign accept = found & ~mem_reset_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q <= '0;
      end else if (accept) begin
        rr_q <= pick + 1'b1;
      end
    end

    for (genvar i = 0; i < VCACHES_PER_CHANNEL; i++) begin : g_yumi
      assign req_yumi_o[c*VCACHES_PER_CHANNEL + i] = accept && (pick == SRC_WIDTH'(i));
    end

    assign ch_v_o[c]    = accept;
    assign ch_op_o[c]   = req_op_i[c*VCACHES_PER_CHANNEL + int'(pick)];
    assign ch_addr_o[c] = req_addr_i[c*VCACHES_PER_CHANNEL + int'(pick)];
    assign ch_data_o[c] = req_data_i[c*VCACHES_PER_CHANNEL + int'(pick)];
    assign ch_src_o[c]  = pick;
  end

  // return path
  for (genvar k = 0; k < NUM_VCACHES; k++) begin : g_resp
    localparam int CH = k / VCACHES_PER_CHANNEL;
    assign resp_v_o[k] = ret_v_i[CH] &&
                         (ret_src_i[CH] == SRC_WIDTH'(k % VCACHES_PER_CHANNEL));
    assign resp_data_o[k] = ret_data_i[CH];
  end

endmodule

`default_nettype wire

// File: design/mc_cache_to_test_dram.sv
// Converts one channel's granted cache DMA request into a test DRAM access.
// The request is registered, the byte address is remapped to the channel
// word address, and reads are tracked so the return lands a fixed
// MEM_READ_LATENCY cycles after the accept.
`timescale 1ns/1ns
`default_nettype none

module mc_cache_to_test_dram
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire                  mem_reset_i,

  input  wire                  ch_v_i,
  input  wire                  ch_op_i,
  input  cache_addr_t          ch_addr_i,
  input  dma_data_t            ch_data_i,
  input  wire  [SRC_WIDTH-1:0] ch_src_i,

  output logic                 mem_v_o,
  output logic                 mem_write_o,
  output dram_ch_addr_t        mem_addr_o,
  output dma_data_t            mem_wdata_o,
  input  dma_data_t            mem_rdata_i,

  output logic                 ret_v_o,
  output logic [SRC_WIDTH-1:0] ret_src_o,
  output dma_data_t            ret_data_o
);

  logic                                     req_v_q;
  dram_op_e                                 op_q;
  cache_addr_t                              addr_q;
  dma_data_t                                data_q;
  logic [SRC_WIDTH-1:0]                     src_q;
  logic                                     rd_accept;
  logic [MEM_READ_LATENCY-1:0]              rd_v_q;
  logic [MEM_READ_LATENCY-1:0][SRC_WIDTH-1:0] rd_src_q;
  // dram data shows up two cycles after accept
  dma_data_t [MEM_READ_LATENCY-3:0]         rd_data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_v_q <= 1'b0;
      rd_v_q  <= '0;
    end else if (mem_reset_i) begin
      req_v_q <= 1'b0;
      rd_v_q  <= '0;
    end else begin
      req_v_q <= ch_v_i;
      rd_v_q  <= {rd_v_q[MEM_READ_LATENCY-2:0], rd_accept};
    end
  end

  assign rd_accept = ch_v_i && (ch_op_i == DRAM_READ);

  always_ff @(posedge clk_i) begin
    if (ch_v_i) begin
      op_q   <= dram_op_e'(ch_op_i);
      addr_q <= ch_addr_i;
      data_q <= ch_data_i;
      src_q  <= ch_src_i;
    end
    rd_src_q     <= {rd_src_q[MEM_READ_LATENCY-2:0], ch_src_i};
    rd_data_q[0] <= mem_rdata_i;
    for (int i = 1; i < MEM_READ_LATENCY - 2; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
  end

  assign mem_v_o     = req_v_q;
  assign mem_write_o = (op_q == DRAM_WRITE);
  assign mem_wdata_o = data_q;

  // bank bit goes between row and bank, byte offset is dropped
  assign mem_addr_o = {addr_q[RO_LSB +: RO_WIDTH],
                       src_q,
                       addr_q[BA_LSB +: BA_WIDTH],
                       addr_q[CO_LSB +: CO_WIDTH]};

  assign ret_v_o    = rd_v_q[MEM_READ_LATENCY-1];
  assign ret_src_o  = rd_src_q[MEM_READ_LATENCY-1];
  assign ret_data_o = rd_data_q[MEM_READ_LATENCY-3];

endmodule

`default_nettype wire

// File: design/mc_test_dram.sv
// One channel of word-wide test memory. Contents start at zero, a write
// is stored on the request cycle and a read is returned one cycle later.
`timescale 1ns/1ns
`default_nettype none

module mc_test_dram
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
(
  input  wire           clk_i,
  input  wire           mem_v_i,
  input  wire           mem_write_i,
  input  dram_ch_addr_t mem_addr_i,
  input  dma_data_t     mem_wdata_i,
  output dma_data_t     mem_rdata_o
);

  dma_data_t mem_q [DRAM_WORDS] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (mem_v_i && mem_write_i) begin
      mem_q[mem_addr_i] <= mem_wdata_i;
    end
  end

  // registered read port
  always_ff @(posedge clk_i) begin
    if (mem_v_i && !mem_write_i) begin
      mem_rdata_o <= mem_q[mem_addr_i];
    end
  end

endmodule

`default_nettype wire

// File: design/mc_mem_sys.sv
// Memory side of the manycore harness: reset sequencer, DMA channel map,
// and per channel one converter and one test DRAM. Vcache k sits on
// channel k / VCACHES_PER_CHANNEL with bank bit k % VCACHES_PER_CHANNEL.
`timescale 1ns/1ns
`default_nettype none

module mc_mem_sys
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
(
  input  wire                           clk_i,
  input  wire                           rst_n_i,
  output logic                          tag_done_o,

  input  wire  [NUM_VCACHES-1:0]        req_v_i,
  input  dram_op_e [NUM_VCACHES-1:0]    req_op_i,
  input  cache_addr_t [NUM_VCACHES-1:0] req_addr_i,
  input  dma_data_t   [NUM_VCACHES-1:0] req_data_i,
  output logic [NUM_VCACHES-1:0]        req_yumi_o,
  output logic [NUM_VCACHES-1:0]        resp_v_o,
  output dma_data_t   [NUM_VCACHES-1:0] resp_data_o
);

  logic                                  mem_reset;

  logic [NUM_CHANNELS-1:0]               ch_v;
  logic [NUM_CHANNELS-1:0]               ch_op;
  cache_addr_t [NUM_CHANNELS-1:0]        ch_addr;
  dma_data_t   [NUM_CHANNELS-1:0]        ch_data;
  logic [NUM_CHANNELS-1:0][SRC_WIDTH-1:0] ch_src;

  logic [NUM_CHANNELS-1:0]               mem_v;
  logic [NUM_CHANNELS-1:0]               mem_write;
  dram_ch_addr_t [NUM_CHANNELS-1:0]      mem_addr;
  dma_data_t   [NUM_CHANNELS-1:0]        mem_wdata;
  dma_data_t   [NUM_CHANNELS-1:0]        mem_rdata;

  logic [NUM_CHANNELS-1:0]               ret_v;
  logic [NUM_CHANNELS-1:0][SRC_WIDTH-1:0] ret_src;
  dma_data_t   [NUM_CHANNELS-1:0]        ret_data;

  mc_reset_sequencer i_mc_reset_sequencer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tag_done_o  (tag_done_o),
    .mem_reset_o (mem_reset)
  );

  mc_dma_channel_map i_mc_dma_channel_map (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_reset_i (mem_reset),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_yumi_o  (req_yumi_o),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o),
    .ch_v_o      (ch_v),
    .ch_op_o     (ch_op),
    .ch_addr_o   (ch_addr),
    .ch_data_o   (ch_data),
    .ch_src_o    (ch_src),
    .ret_v_i     (ret_v),
    .ret_src_i   (ret_src),
    .ret_data_i  (ret_data)
  );

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_ch
    mc_cache_to_test_dram i_mc_cache_to_test_dram (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .mem_reset_i (mem_reset),
      .ch_v_i      (ch_v[c]),
      .ch_op_i     (ch_op[c]),
      .ch_addr_i   (ch_addr[c]),
      .ch_data_i   (ch_data[c]),
      .ch_src_i    (ch_src[c]),
      .mem_v_o     (mem_v[c]),
      .mem_write_o (mem_write[c]),
      .mem_addr_o  (mem_addr[c]),
      .mem_wdata_o (mem_wdata[c]),
      .mem_rdata_i (mem_rdata[c]),
      .ret_v_o     (ret_v[c]),
      .ret_src_o   (ret_src[c]),
      .ret_data_o  (ret_data[c])
    );

    mc_test_dram i_mc_test_dram (
      .clk_i       (clk_i),
      .mem_v_i     (mem_v[c]),
      .mem_write_i (mem_write[c]),
      .mem_addr_i  (mem_addr[c]),
      .mem_wdata_i (mem_wdata[c]),
      .mem_rdata_o (mem_rdata[c])
    );
  end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Testbench clock and power-on reset for the memory system testbench.
// The clock runs at 40 ns; rst_n_o stays low for the first 10 rising edges.
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // released on a rising edge, so the DUT sees a full reset cycle count
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/mc_mem_sys_assertions.sv
// Protocol checks bound into the memory system top level.
// Checks yumi against v, the reset quiet period and the read response timing.
`timescale 1ns/1ns
`default_nettype none

module mc_mem_sys_assertions
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
(
  input wire                        clk_i,
  input wire                        rst_n_i,
  input wire                        tag_done_i,
  input wire      [NUM_VCACHES-1:0] req_v_i,
  input dram_op_e [NUM_VCACHES-1:0] req_op_i,
  input wire      [NUM_VCACHES-1:0] req_yumi_i,
  input wire      [NUM_VCACHES-1:0] resp_v_i
);

  int fail_count = 0;
  logic [NUM_VCACHES-1:0] rd_accept;

  always_comb begin
    for (int k = 0; k < NUM_VCACHES; k++) begin
      rd_accept[k] = req_v_i[k] && req_yumi_i[k] && (req_op_i[k] == DRAM_READ);
    end
  end

  yumi_needs_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_yumi_i & ~req_v_i) == '0)
    else begin
      fail_count++;
      $error("req_yumi_o high without req_v_i");
    end

  no_yumi_before_tag_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !tag_done_i |-> (req_yumi_i == '0))
    else begin
      fail_count++;
      $error("request accepted before tag_done_o");
    end

  // every response pulse pairs with a read accepted a fixed latency earlier
  resp_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_i & ~$past(rd_accept, MEM_READ_LATENCY)) == '0)
    else begin
      fail_count++;
      $error("resp_v_o without a read accepted MEM_READ_LATENCY cycles earlier");
    end

endmodule

bind mc_mem_sys mc_mem_sys_assertions i_mc_mem_sys_assertions (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .tag_done_i (tag_done_o),
  .req_v_i    (req_v_i),
  .req_op_i   (req_op_i),
  .req_yumi_i (req_yumi_o),
  .resp_v_i   (resp_v_o)
);

`default_nettype wire

// File: tests/mc_mem_sys_tb.sv
// Testbench for the memory system: reset timing, write/read, per-vcache
// isolation, channel contention and random traffic. A shadow memory per
// vcache predicts read data; responses are compared at the falling edge.
`timescale 1ns/1ns
`default_nettype none

module mc_mem_sys_tb
  import mc_cfg_pkg::*;
  import mc_dram_pkg::*;
();

  localparam int WAIT_LIMIT = 100;
  localparam int ADDR_POOL  = 16;

  logic                          clk;
  logic                          rst_n;
  logic                          tag_done;
  logic        [NUM_VCACHES-1:0] req_v_i;
  dram_op_e    [NUM_VCACHES-1:0] req_op_i;
  cache_addr_t [NUM_VCACHES-1:0] req_addr_i;
  dma_data_t   [NUM_VCACHES-1:0] req_data_i;
  logic        [NUM_VCACHES-1:0] req_yumi_o;
  logic        [NUM_VCACHES-1:0] resp_v_o;
  dma_data_t   [NUM_VCACHES-1:0] resp_data_o;

  int          errors = 0;
  int          checks = 0;
  int          now_cycle = 0;
  int          contenders_done = 0;
  string       test_name = "init";
  dma_data_t   shadow [int];
  int          pend_vc [$];
  int          pend_cycle [$];
  dma_data_t   pend_data [$];
  cache_addr_t addr_pool [ADDR_POOL];

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mc_mem_sys i_mc_mem_sys (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .tag_done_o  (tag_done),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_yumi_o  (req_yumi_o),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

  // byte offset is not part of the word address
  function automatic int shadow_key(int vc, cache_addr_t addr);
    return (vc << (ADDR_WIDTH - BYTE_OFFSET_WIDTH)) + int'(addr >> BYTE_OFFSET_WIDTH);
  endfunction

  // reference model: last word this vcache wrote there, zero if none
  function automatic dma_data_t expected_read(int vc, cache_addr_t addr);
    int key;
    key = shadow_key(vc, addr);
    if (shadow.exists(key)) begin
      return shadow[key];
    end
    return '0;
  endfunction

  task automatic abort_run(string what);
    $display("ERROR: %s: timed out waiting for %s", test_name, what);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic check_int(string what, int expected, int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_accept_wait(int vc, int waited);
    checks++;
    assert (waited <= VCACHES_PER_CHANNEL) else begin
      errors++;
      $display("FAILED %s: vcache %0d accept wait expected <= %0d actual %0d",
               test_name, vc, VCACHES_PER_CHANNEL, waited);
    end
  endtask

  task automatic check_response(int k);
    int idx;
    idx = -1;
    for (int i = pend_vc.size() - 1; i >= 0; i--) begin
      if (pend_vc[i] == k) idx = i;
    end
    checks++;
    assert (idx >= 0) else begin
      errors++;
      $display("ERROR: %s: response on vcache %0d with no read outstanding", test_name, k);
    end
    if (idx < 0) return;
    check_int($sformatf("vcache %0d response cycle", k), pend_cycle[idx], now_cycle);
    checks++;
    assert (resp_data_o[k] == pend_data[idx]) else begin
      errors++;
      $display("FAILED %s: vcache %0d read data expected %h actual %h",
               test_name, k, pend_data[idx], resp_data_o[k]);
    end
    pend_vc.delete(idx);
    pend_cycle.delete(idx);
    pend_data.delete(idx);
  endtask

  // compare process, samples at the falling edge
  initial begin : compare
    forever begin
      @(negedge clk);
      now_cycle++;
      for (int k = 0; k < NUM_VCACHES; k++) begin
        if (resp_v_o[k]) check_response(k);
      end
      for (int k = 0; k < NUM_VCACHES; k++) begin
        if (req_v_i[k] && req_yumi_o[k]) begin
          if (req_op_i[k] == DRAM_WRITE) begin
            shadow[shadow_key(k, req_addr_i[k])] = req_data_i[k];
          end else begin
            pend_vc.push_back(k);
            pend_cycle.push_back(now_cycle + MEM_READ_LATENCY);
            pend_data.push_back(expected_read(k, req_addr_i[k]));
          end
        end
      end
    end
  end

  // holds the request until accepted; waited counts cycles including the accept
  task automatic issue(int vc, dram_op_e op, cache_addr_t addr, dma_data_t data,
                       output int waited);
    @(posedge clk);
    req_v_i[vc]    <= 1'b1;
    req_op_i[vc]   <= op;
    req_addr_i[vc] <= addr;
    req_data_i[vc] <= data;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run("request accept");
    end while (!req_yumi_o[vc]);
  endtask

  task automatic release_req(int vc);
    @(posedge clk);
    req_v_i[vc] <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (pend_vc.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("read responses");
    end
  endtask

  task automatic write_then_read(int vc, cache_addr_t addr, dma_data_t data);
    int waited;
    issue(vc, DRAM_WRITE, addr, data, waited);
    issue(vc, DRAM_READ, addr, '0, waited);
    release_req(vc);
  endtask

  task automatic contend(int vc);
    int waited;
    dram_op_e op;
    for (int i = 0; i < 8; i++) begin
      op = (i % 2 == 0) ? DRAM_WRITE : DRAM_READ;
      issue(vc, op, cache_addr_t'(12'h100 + 4 * (i / 2)),
            dma_data_t'(32'hc0de_0000 + vc * 16 + i), waited);
      check_accept_wait(vc, waited);
    end
    release_req(vc);
    contenders_done++;
  endtask

  // vcaches 2 and 3 share channel 1
  task automatic watch_alternation();
    logic [1:0] last;
    int n;
    last = '0;
    n = 0;
    while (contenders_done < 2) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("contention traffic");
      if (req_v_i[3:2] == 2'b11 && req_yumi_o[3:2] != 2'b00) begin
        checks++;
        assert (req_yumi_o[3:2] != last) else begin
          errors++;
          $display("ERROR: %s: channel 1 granted the same vcache twice in a row", test_name);
        end
        last = req_yumi_o[3:2];
      end
    end
  endtask

  task automatic random_traffic(int vc, int count);
    int waited;
    dram_op_e op;
    for (int i = 0; i < count; i++) begin
      op = ($urandom % 2 == 0) ? DRAM_READ : DRAM_WRITE;
      issue(vc, op, addr_pool[$urandom % ADDR_POOL], dma_data_t'($urandom), waited);
      check_accept_wait(vc, waited);
    end
    release_req(vc);
  endtask

  initial begin : main
    int n;
    int assert_fails;
    logic [NUM_VCACHES-1:0] taken;
    logic [NUM_VCACHES-1:0] early;
    void'($urandom(32'h51f9));
    req_v_i    = '0;
    req_addr_i = '0;
    req_data_i = '0;
    for (int k = 0; k < NUM_VCACHES; k++) begin
      req_op_i[k] = DRAM_WRITE;
    end

    // 1: writes of zero held on every port through reset
    test_name = "reset_timing";
    @(posedge clk);
    req_v_i <= '1;
    n = 0;
    while (!rst_n) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("reset release");
    end
    n = 0;
    early = '0;
    do begin
      @(negedge clk);
      n++;
      early |= req_yumi_o;
      if (n > WAIT_LIMIT) abort_run("tag done");
    end while (!tag_done);
    check_int("cycles to tag done", TAG_PROGRAM_CYCLES, n);
    check_int("accepts before tag done", 0, int'(early));
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("first accept");
    end while (req_yumi_o == '0);
    check_int("cycles from tag done to first accept", RESET_DEPTH, n);
    taken = req_yumi_o;
    n = 0;
    while (taken != '1) begin
      @(posedge clk);
      req_v_i <= ~taken;
      @(negedge clk);
      taken |= req_yumi_o;
      n++;
      if (n > WAIT_LIMIT) abort_run("held requests");
    end
    @(posedge clk);
    req_v_i <= '0;

    // 2
    test_name = "write_read";
    write_then_read(1, 12'h5a4, 32'hcafe_0001);
    wait_idle();

    // 3: same address on every vcache
    test_name = "isolation";
    fork
      write_then_read(0, 12'h2c8, 32'h1111_0a0a);
      write_then_read(1, 12'h2c8, 32'h2222_0b0b);
      write_then_read(2, 12'h2c8, 32'h3333_0c0c);
      write_then_read(3, 12'h2c8, 32'h4444_0d0d);
    join
    wait_idle();

    // 4
    test_name = "contention";
    fork
      contend(2);
      contend(3);
      watch_alternation();
    join
    wait_idle();

    // 5: 200 operations over four vcaches
    test_name = "random";
    for (int i = 0; i < ADDR_POOL; i++) begin
      addr_pool[i] = cache_addr_t'($urandom);
    end
    fork
      random_traffic(0, 50);
      random_traffic(1, 50);
      random_traffic(2, 50);
      random_traffic(3, 50);
    join
    wait_idle();

    repeat (MEM_READ_LATENCY) @(negedge clk);
    assert_fails = i_mc_mem_sys.i_mc_mem_sys_assertions.fail_count;
    errors += assert_fails;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/mc_cfg_pkg.sv
design/mc_dram_pkg.sv
design/mc_reset_sequencer.sv
design/mc_dma_channel_map.sv
design/mc_cache_to_test_dram.sv
design/mc_test_dram.sv
design/mc_mem_sys.sv
tests/tb_clock_gen.sv
tests/mc_mem_sys_assertions.sv
tests/mc_mem_sys_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module mc_mem_sys_tb \
  -f files.f -o mc_mem_sys_tb || { echo "build failed"; exit 1; }
./obj_dir/mc_mem_sys_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
